//--- hw/imuldiv_defs.svh
//--------------------------------------------------------------------------
// width and iteration count macros for the multiply/divide unit
//--------------------------------------------------------------------------

`ifndef IMULDIV_DEFS_SVH
`define IMULDIV_DEFS_SVH

// operand width, fixed by the instruction set
`define IMULDIV_XLEN 32

// full product, or remainder and quotient side by side
`define IMULDIV_RLEN 64

// one result bit per calc cycle
`define IMULDIV_STEPS 32

// step counter width, holds 0 to 32
`define IMULDIV_CNT_W 6

`endif

//--- hw/imuldiv_pkg.sv
//--------------------------------------------------------------------------
// shared types: operand and result vectors, opcode, request and response
// messages, FSM state encodings
//--------------------------------------------------------------------------

`default_nettype none

`include "imuldiv_defs.svh"

package imuldiv_pkg;

  // data widths
  typedef logic [`IMULDIV_XLEN-1:0] operand_t;
  typedef logic [`IMULDIV_RLEN-1:0] result_t;

  // signed forms first, unsigned forms follow
  typedef enum logic [1:0] {
    op_mul  = 2'd0,
    op_mulu = 2'd1,
    op_div  = 2'd2,
    op_divu = 2'd3
  } muldiv_op_e;

  // request message, 66 bits
  typedef struct packed {
    muldiv_op_e op;
    operand_t   a;
    operand_t   b;
  } muldiv_req_t;

  // response message
  // divide packs remainder in the upper half, quotient in the lower half
  typedef struct packed {
    result_t result;
  } muldiv_resp_t;

  typedef enum logic [1:0] {div_idle, div_calc, div_done} div_state_e;
  typedef enum logic [1:0] {mul_idle, mul_calc, mul_done} mul_state_e;

endpackage

`default_nettype wire

//--- hw/int_div_dpath.sv
//--------------------------------------------------------------------------
// restoring divider datapath: operand magnitudes, remainder/quotient
// register, shift-subtract step and final sign fix-up
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_defs.svh"

module int_div_dpath
  import imuldiv_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire operand_t req_a,
  input  wire operand_t req_b,
  input  wire logic     req_signed,
  input  wire logic     a_en,
  input  wire logic     b_en,
  input  wire logic     a_sel,
  input  wire logic     sub_sel,
  output logic          sub_neg,
  output result_t       resp_result
);

  //------------------------------------------------------------------------
  // operand magnitudes
  //------------------------------------------------------------------------

  logic     a_neg;
  logic     b_neg;
  operand_t a_mag;
  operand_t b_mag;

  // only signed mode treats the top bit as a sign
  assign a_neg = req_signed && req_a[`IMULDIV_XLEN-1];
  assign b_neg = req_signed && req_b[`IMULDIV_XLEN-1];
  assign a_mag = a_neg ? (~req_a + 1'b1) : req_a;
  assign b_mag = b_neg ? (~req_b + 1'b1) : req_b;

  //------------------------------------------------------------------------
  // remainder/quotient register and divisor
  //------------------------------------------------------------------------

  // rq_reg holds {remainder, quotient}, one guard bit on top
  logic [`IMULDIV_RLEN:0] rq_reg;
  logic [`IMULDIV_RLEN:0] div_reg;
  logic [`IMULDIV_RLEN:0] shifted;
  logic [`IMULDIV_RLEN:0] diff;
  logic [`IMULDIV_RLEN:0] rq_next;
  logic                   quot_neg;
  logic                   rem_neg;
  logic                   div_zero;

  assign shifted = rq_reg << 1;
  assign diff    = shifted - div_reg;
  // borrow out of the trial subtraction
  assign sub_neg = diff[`IMULDIV_RLEN];

  // initial load puts the dividend magnitude in the quotient half
  // sub_sel keeps the difference and sets the new quotient bit
  always_comb begin
    if (!a_sel) begin
      rq_next = {{(`IMULDIV_XLEN+1){1'b0}}, a_mag};
    end else if (sub_sel) begin
      rq_next = {diff[`IMULDIV_RLEN:1], 1'b1};
    end else begin
      rq_next = shifted;
    end
  end

  always_ff @(posedge clk) begin
    if (a_en) begin
      rq_reg <= rq_next;
    end
    // divisor sits aligned with the remainder half
    if (b_en) begin
      div_reg <= {1'b0, b_mag, {`IMULDIV_XLEN{1'b0}}};
    end
  end

  // result sign flags, captured with the divisor
  always_ff @(posedge clk) begin
    if (reset) begin
      quot_neg <= 1'b0;
      rem_neg  <= 1'b0;
      div_zero <= 1'b0;
    end else if (b_en) begin
      quot_neg <= a_neg ^ b_neg;
      rem_neg  <= a_neg;
      div_zero <= (req_b == '0);
    end
  end

  //------------------------------------------------------------------------
  // sign fix-up
  //------------------------------------------------------------------------

  operand_t quot_mag;
  operand_t rem_mag;
  operand_t quot;
  operand_t rem;

  assign quot_mag = rq_reg[`IMULDIV_XLEN-1:0];
  assign rem_mag  = rq_reg[`IMULDIV_RLEN-1:`IMULDIV_XLEN];

  // zero divisor forces all ones, the remainder is already the dividend
  // most negative / -1 wraps back to the most negative value by itself
  assign quot = div_zero ? '1 : (quot_neg ? (~quot_mag + 1'b1) : quot_mag);
  // remainder follows the dividend sign
  assign rem  = rem_neg ? (~rem_mag + 1'b1) : rem_mag;

  assign resp_result = {rem, quot};

endmodule

`default_nettype wire

//--- hw/int_div_ctrl.sv
//--------------------------------------------------------------------------
// divider control FSM with step counter, drives datapath enables/selects
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_defs.svh"

module int_div_ctrl
  import imuldiv_pkg::*;
(
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic req_val,
  input  wire logic resp_rdy,
  input  wire logic sub_neg,
  output logic      req_rdy,
  output logic      resp_val,
  output logic      a_en,
  output logic      b_en,
  output logic      a_sel,
  output logic      sub_sel
);

  div_state_e                 state;
  logic [`IMULDIV_CNT_W-1:0] count;
  logic                       last_step;

  assign last_step = (count == (`IMULDIV_STEPS - 1));

  // accept edge -> 32 calc cycles -> done
  // resp_val is first sampled high on the 33rd edge after accept
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= div_idle;
      count <= '0;
    end else begin
      case (state)
        div_idle: begin
          if (req_val) begin
            state <= div_calc;
            count <= '0;
          end
        end
        div_calc: begin
          if (last_step) begin
            state <= div_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        div_done: begin
          // hold the result until the response transfer
          if (resp_rdy) begin
            state <= div_idle;
          end
        end
        default: begin
          state <= div_idle;
        end
      endcase
    end
  end

  always_comb begin
    req_rdy  = 1'b0;
    resp_val = 1'b0;
    a_en     = 1'b0;
    b_en     = 1'b0;
    a_sel    = 1'b0;
    sub_sel  = 1'b0;
    case (state)
      div_idle: begin
        // load operands with the initial select on accept
        req_rdy = 1'b1;
        a_en    = req_val;
        b_en    = req_val;
      end
      div_calc: begin
        a_en    = 1'b1;
        a_sel   = 1'b1;
        // keep the difference only when it did not borrow
        sub_sel = !sub_neg;
      end
      div_done: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/int_mul_iterative.sv
//--------------------------------------------------------------------------
// shift-and-add multiplier, one multiplier bit per cycle, own small FSM
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_defs.svh"

module int_mul_iterative
  import imuldiv_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire logic     req_val,
  input  wire operand_t req_a,
  input  wire operand_t req_b,
  input  wire logic     req_signed,
  input  wire logic     resp_rdy,
  output logic          req_rdy,
  output logic          resp_val,
  output result_t       resp_result
);

  mul_state_e                 state;
  logic [`IMULDIV_CNT_W-1:0] count;
  logic                       last_step;

  //------------------------------------------------------------------------
  // operand magnitudes and product sign
  //------------------------------------------------------------------------

  logic     a_neg;
  logic     b_neg;
  operand_t a_mag;
  operand_t b_mag;

  assign a_neg = req_signed && req_a[`IMULDIV_XLEN-1];
  assign b_neg = req_signed && req_b[`IMULDIV_XLEN-1];
  assign a_mag = a_neg ? (~req_a + 1'b1) : req_a;
  assign b_mag = b_neg ? (~req_b + 1'b1) : req_b;

  //------------------------------------------------------------------------
  // datapath registers
  //------------------------------------------------------------------------

  result_t  acc;
  // multiplicand, shifted left one place per step
  result_t  mcand;
  // multiplier, shifted right so bit 0 is the current bit
  operand_t mplier;
  logic     prod_neg;

  always_ff @(posedge clk) begin
    if (state == mul_idle && req_val) begin
      acc      <= '0;
      mcand    <= {{`IMULDIV_XLEN{1'b0}}, a_mag};
      mplier   <= b_mag;
      prod_neg <= a_neg ^ b_neg;
    end else if (state == mul_calc) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // magnitude product is below 2^63 in signed mode, negation is safe
  assign resp_result = prod_neg ? (~acc + 1'b1) : acc;

  //------------------------------------------------------------------------
  // control
  //------------------------------------------------------------------------

  assign last_step = (count == (`IMULDIV_STEPS - 1));
  assign req_rdy   = (state == mul_idle);
  assign resp_val  = (state == mul_done);

  // same phase timing as the divider, 33 edges from accept to response
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= mul_idle;
      count <= '0;
    end else begin
      case (state)
        mul_idle: begin
          if (req_val) begin
            state <= mul_calc;
            count <= '0;
          end
        end
        mul_calc: begin
          if (last_step) begin
            state <= mul_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        mul_done: begin
          if (resp_rdy) begin
            state <= mul_idle;
          end
        end
        default: begin
          state <= mul_idle;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/imuldiv_unit.sv
//--------------------------------------------------------------------------
// multiply/divide unit top: request steering, in-flight owner tracking,
// response selection
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module imuldiv_unit
  import imuldiv_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire muldiv_req_t req_msg,
  input  wire logic        req_val,
  output logic             req_rdy,
  output muldiv_resp_t     resp_msg,
  output logic             resp_val,
  input  wire logic        resp_rdy
);

  // opcode decode
  logic is_div;
  logic req_signed;

  assign is_div     = (req_msg.op == op_div) || (req_msg.op == op_divu);
  assign req_signed = (req_msg.op == op_div) || (req_msg.op == op_mul);

  // in-flight tracking, owner_div names the block holding the response
  logic in_flight;
  logic owner_div;
  logic req_fire;
  logic resp_fire;

  // per-block handshake
  logic    div_req_val;
  logic    div_req_rdy;
  logic    div_resp_val;
  logic    div_resp_rdy;
  result_t div_result;
  logic    mul_req_val;
  logic    mul_req_rdy;
  logic    mul_resp_val;
  logic    mul_resp_rdy;
  result_t mul_result;

  // divider control to datapath
  logic a_en;
  logic b_en;
  logic a_sel;
  logic sub_sel;
  logic sub_neg;

  //------------------------------------------------------------------------
  // request steering
  //------------------------------------------------------------------------

  // one operation at a time, no overlap between the blocks
  assign req_rdy     = div_req_rdy && mul_req_rdy && !in_flight;
  assign req_fire    = req_val && req_rdy;
  assign div_req_val = req_val && !in_flight && is_div;
  assign mul_req_val = req_val && !in_flight && !is_div;

  always_ff @(posedge clk) begin
    if (reset) begin
      in_flight <= 1'b0;
      owner_div <= 1'b0;
    end else if (req_fire) begin
      in_flight <= 1'b1;
      owner_div <= is_div;
    end else if (resp_fire) begin
      // req_rdy comes back on the next cycle
      in_flight <= 1'b0;
    end
  end

  //------------------------------------------------------------------------
  // response selection
  //------------------------------------------------------------------------

  assign resp_val        = in_flight && (owner_div ? div_resp_val : mul_resp_val);
  assign resp_fire       = resp_val && resp_rdy;
  assign resp_msg.result = owner_div ? div_result : mul_result;
  assign div_resp_rdy    = resp_rdy && owner_div;
  assign mul_resp_rdy    = resp_rdy && !owner_div;

  //------------------------------------------------------------------------
  // blocks
  //------------------------------------------------------------------------

  int_div_ctrl int_div_ctrl_i (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .resp_rdy (div_resp_rdy),
    .sub_neg  (sub_neg),
    .req_rdy  (div_req_rdy),
    .resp_val (div_resp_val),
    .a_en     (a_en),
    .b_en     (b_en),
    .a_sel    (a_sel),
    .sub_sel  (sub_sel)
  );

  int_div_dpath int_div_dpath_i (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_msg.a),
    .req_b       (req_msg.b),
    .req_signed  (req_signed),
    .a_en        (a_en),
    .b_en        (b_en),
    .a_sel       (a_sel),
    .sub_sel     (sub_sel),
    .sub_neg     (sub_neg),
    .resp_result (div_result)
  );

  int_mul_iterative int_mul_iterative_i (
    .clk         (clk),
    .reset       (reset),
    .req_val     (mul_req_val),
    .req_a       (req_msg.a),
    .req_b       (req_msg.b),
    .req_signed  (req_signed),
    .resp_rdy    (mul_resp_rdy),
    .req_rdy     (mul_req_rdy),
    .resp_val    (mul_resp_val),
    .resp_result (mul_result)
  );

endmodule

`default_nettype wire

//--- test/imuldiv_assertions.sv
//--------------------------------------------------------------------------
// concurrent assertions on the unit handshake and reset behavior
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module imuldiv_assertions
  import imuldiv_pkg::*;
(
  input  wire logic         clk,
  input  wire logic         reset,
  input  wire logic         req_val,
  input  wire logic         req_rdy,
  input  wire logic         resp_val,
  input  wire logic         resp_rdy,
  input  wire muldiv_resp_t resp_msg
);

  // assertion failures seen so far
  int fail_count = 0;

  // pending operation as seen from the two handshakes
  logic pending;

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
    end else if (req_val && req_rdy) begin
      pending <= 1'b1;
    end else if (resp_val && resp_rdy) begin
      pending <= 1'b0;
    end
  end

  // a stalled response keeps its valid and its data
  property resp_held;
    @(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_msg));
  endproperty

  // no new request while one is pending
  property no_accept_in_flight;
    @(posedge clk) disable iff (reset)
    pending |-> !req_rdy;
  endproperty

  // reset clears any pending response
  property quiet_after_reset;
    @(posedge clk)
    reset |=> !resp_val;
  endproperty

  resp_held_a: assert property (resp_held) else begin
    fail_count++;
    $error("response valid dropped or message changed under back-pressure");
  end

  no_accept_in_flight_a: assert property (no_accept_in_flight) else begin
    fail_count++;
    $error("request ready high while an operation is in flight");
  end

  quiet_after_reset_a: assert property (quiet_after_reset) else begin
    fail_count++;
    $error("response valid high right after reset");
  end

endmodule

`default_nettype wire

//--- test/imuldiv_checker.sv
//--------------------------------------------------------------------------
// response checker: expected-result queue, in-order compare, latency check,
// error and check counters
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_defs.svh"

module imuldiv_checker
  import imuldiv_pkg::*;
(
  input  wire logic         clk,
  input  wire logic         reset,
  input  wire logic         req_val,
  input  wire logic         req_rdy,
  input  wire logic         resp_val,
  input  wire logic         resp_rdy,
  input  wire muldiv_resp_t resp_msg,
  input  wire result_t      exp_result,
  input  wire logic         end_run,
  output int                checks,
  output int                errors
);

  // 32 calc steps plus the accept edge
  localparam int LATENCY = `IMULDIV_STEPS + 1;

  result_t exp_q [$];
  result_t exp_now;
  int      cycles;
  logic    timing;
  logic    end_seen;

  always @(posedge clk) begin
    if (reset) begin
      exp_q.delete();
      checks   = 0;
      errors   = 0;
      cycles   = 0;
      timing   = 1'b0;
      end_seen = 1'b0;
    end else begin
      // count edges from accept to the first edge that sees resp_val
      if (timing) begin
        cycles = cycles + 1;
        if (resp_val) begin
          timing = 1'b0;
          if (cycles != LATENCY) begin
            errors = errors + 1;
            $display("Fail: time %0d ns: response after %0d cycles, expected %0d",
                     $time, cycles, LATENCY);
          end
        end
      end
      // response transfer pops the oldest expectation
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          errors = errors + 1;
          $display("response at time %0d ns arrived with no request outstanding", $time);
        end else begin
          exp_now = exp_q.pop_front();
          checks  = checks + 1;
          if (resp_msg.result !== exp_now) begin
            errors = errors + 1;
            $display("Fail: time %0d ns: result %h, expected %h",
                     $time, resp_msg.result, exp_now);
          end
        end
      end
      // request transfer pushes the row expectation
      if (req_val && req_rdy) begin
        exp_q.push_back(exp_result);
        timing = 1'b1;
        cycles = 0;
      end
      // anything left over at the end was lost
      if (end_run && !end_seen) begin
        end_seen = 1'b1;
        if (exp_q.size() != 0) begin
          errors = errors + exp_q.size();
          $display("%0d expected responses never arrived", exp_q.size());
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- test/imuldiv_tb.sv
//--------------------------------------------------------------------------
// testbench top with clock, reset, stimulus table of directed and random
// rows, reference model, response back-pressure, watchdog and closing report
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_defs.svh"

module imuldiv_tb
  import imuldiv_pkg::*;
();

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;
  localparam int LATENCY      = `IMULDIV_STEPS + 1;
  localparam int MAX_STALL    = 7;
  localparam int N_DIR        = 18;
  localparam int N_RAND       = 32;
  localparam int N_ROWS       = N_DIR + N_RAND;
  // twice the rows times latency plus stall plus slack
  localparam int WATCHDOG_NS  =
    (RESET_CYCLES + N_ROWS * (LATENCY + MAX_STALL + 4)) * CLK_PERIOD * 2;

  // one request with its expected response
  typedef struct packed {
    muldiv_op_e op;
    operand_t   a;
    operand_t   b;
    result_t    exp;
  } row_t;

  logic         clk = 1'b0;
  logic         reset;
  muldiv_req_t  req_msg;
  logic         req_val;
  logic         req_rdy;
  muldiv_resp_t resp_msg;
  logic         resp_val;
  logic         resp_rdy;
  result_t      exp_result;
  logic         end_run;
  int           checks;
  int           errors;
  int           asrt_fails;
  int           resp_count;
  logic [31:0]  lfsr;
  row_t         rows [N_ROWS];

  //------------------------------------------------------------------------
  // DUT, checker, assertions
  //------------------------------------------------------------------------

  imuldiv_unit imuldiv_unit_i (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  imuldiv_checker imuldiv_checker_i (
    .clk        (clk),
    .reset      (reset),
    .req_val    (req_val),
    .req_rdy    (req_rdy),
    .resp_val   (resp_val),
    .resp_rdy   (resp_rdy),
    .resp_msg   (resp_msg),
    .exp_result (exp_result),
    .end_run    (end_run),
    .checks     (checks),
    .errors     (errors)
  );

  bind imuldiv_unit imuldiv_assertions imuldiv_assertions_i (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

  //------------------------------------------------------------------------
  // random bits and reference model
  //------------------------------------------------------------------------

  // galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output logic [31:0] v);
    int k;
    v = '0;
    for (k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // full product, or {remainder, quotient} with the defined special cases
  function automatic result_t ref_result(input muldiv_op_e op, input operand_t a,
                                         input operand_t b);
    int       sa;
    int       sb;
    longint   pa;
    longint   pb;
    result_t  ua;
    result_t  ub;
    operand_t q;
    operand_t r;
    result_t  res;
    sa = a;
    sb = b;
    pa = sa;
    pb = sb;
    ua = {32'h0, a};
    ub = {32'h0, b};
    // zero divisor leaves these as they are
    q  = '1;
    r  = a;
    case (op)
      op_mul:  res = pa * pb;
      op_mulu: res = ua * ub;
      op_divu: begin
        if (b != 0) begin
          q = a / b;
          r = a % b;
        end
        res = {r, q};
      end
      default: begin
        // most negative / -1 overflows
        if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
          q = a;
          r = '0;
        end else if (b != 0) begin
          q = sa / sb;
          r = sa % sb;
        end
        res = {r, q};
      end
    endcase
    return res;
  endfunction

  //------------------------------------------------------------------------
  // stimulus table
  //------------------------------------------------------------------------

  task automatic load_directed();
    // multiply
    rows[0]  = '{op_mulu, 32'h0000_0003, 32'h0000_0007, 64'h0000_0000_0000_0015};
    rows[1]  = '{op_mulu, 32'hffff_ffff, 32'hffff_ffff, 64'hffff_fffe_0000_0001};
    rows[2]  = '{op_mul,  32'hffff_fffd, 32'h0000_0007, 64'hffff_ffff_ffff_ffeb};
    rows[3]  = '{op_mul,  32'h8000_0000, 32'h8000_0000, 64'h4000_0000_0000_0000};
    rows[4]  = '{op_mul,  32'hffff_ffff, 32'hffff_ffff, 64'h0000_0000_0000_0001};
    rows[5]  = '{op_mulu, 32'h8000_0000, 32'h0000_0002, 64'h0000_0001_0000_0000};
    rows[6]  = '{op_mul,  32'h7fff_ffff, 32'h8000_0000, 64'hc000_0000_8000_0000};
    // divide with the remainder following the dividend
    rows[7]  = '{op_divu, 32'h0000_0064, 32'h0000_0007, 64'h0000_0002_0000_000e};
    rows[8]  = '{op_div,  32'hffff_ff9c, 32'h0000_0007, 64'hffff_fffe_ffff_fff2};
    rows[9]  = '{op_div,  32'h0000_0064, 32'hffff_fff9, 64'h0000_0002_ffff_fff2};
    rows[10] = '{op_div,  32'hffff_ff9c, 32'hffff_fff9, 64'hffff_fffe_0000_000e};
    rows[11] = '{op_divu, 32'hffff_ffff, 32'h0000_0010, 64'h0000_000f_0fff_ffff};
    // zero divisor and signed overflow
    rows[12] = '{op_divu, 32'h0000_1234, 32'h0000_0000, 64'h0000_1234_ffff_ffff};
    rows[13] = '{op_div,  32'hffff_fffb, 32'h0000_0000, 64'hffff_fffb_ffff_ffff};
    rows[14] = '{op_div,  32'h8000_0000, 32'hffff_ffff, 64'h0000_0000_8000_0000};
    rows[15] = '{op_divu, 32'h8000_0000, 32'hffff_ffff, 64'h8000_0000_0000_0000};
    rows[16] = '{op_div,  32'h0000_0000, 32'h0000_0005, 64'h0000_0000_0000_0000};
    rows[17] = '{op_divu, 32'h0000_0007, 32'h0000_0064, 64'h0000_0007_0000_0000};
  endtask

  task automatic fill_random();
    int          k;
    logic [31:0] op_bits;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] narrow;
    for (k = N_DIR; k < N_ROWS; k++) begin
      take_bits(2, op_bits);
      take_bits(32, a);
      take_bits(32, b);
      take_bits(1, narrow);
      // small divisor now and then for larger quotients
      if (narrow[0]) begin
        b = b & 32'h0000_00ff;
      end
      rows[k].op  = muldiv_op_e'(op_bits[1:0]);
      rows[k].a   = a;
      rows[k].b   = b;
      rows[k].exp = ref_result(rows[k].op, a, b);
    end
  endtask

  // starts on a falling edge, ends on the falling edge after the accept
  task automatic send_row(input int idx);
    req_msg    = '{rows[idx].op, rows[idx].a, rows[idx].b};
    exp_result = rows[idx].exp;
    req_val    = 1'b1;
    // req_rdy only moves on rising edges
    while (!req_rdy) begin
      @(negedge clk);
    end
    @(negedge clk);
    req_val = 1'b0;
  endtask

  //------------------------------------------------------------------------
  // clock, back-pressure, watchdog, main sequence
  //------------------------------------------------------------------------

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // random stall of 0 to MAX_STALL cycles on every response
  initial begin : resp_drive
    logic [31:0] stall;
    @(negedge reset);
    forever begin
      @(negedge clk);
      if (resp_val) begin
        take_bits(3, stall);
        repeat (stall) @(negedge clk);
        resp_rdy = 1'b1;
        @(negedge clk);
        resp_rdy   = 1'b0;
        resp_count = resp_count + 1;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before all responses arrived", WATCHDOG_NS);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : main_seq
    int i;
    reset      = 1'b1;
    req_val    = 1'b0;
    req_msg    = '0;
    resp_rdy   = 1'b0;
    exp_result = '0;
    end_run    = 1'b0;
    resp_count = 0;
    lfsr       = 32'h2cff9b4b;
    load_directed();
    fill_random();
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    for (i = 0; i < N_ROWS; i++) begin
      send_row(i);
    end
    while (resp_count < N_ROWS) begin
      @(negedge clk);
    end
    // let the checker look for leftovers
    end_run = 1'b1;
    repeat (2) @(negedge clk);
    asrt_fails = imuldiv_unit_i.imuldiv_assertions_i.fail_count;
    $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, asrt_fails);
    if (errors == 0 && asrt_fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+hw
hw/imuldiv_pkg.sv
hw/int_div_dpath.sv
hw/int_div_ctrl.sv
hw/int_mul_iterative.sv
hw/imuldiv_unit.sv
test/imuldiv_assertions.sv
test/imuldiv_checker.sv
test/imuldiv_tb.sv

//--- Makefile
# Verilator build and run for the multiply/divide unit

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := imuldiv_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
